/* common/vga_consts.svh */
// Fixed 640 x 480 at 60 Hz with a 25.175 MHz pixel clock; other modes need new values here.

`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

////////////////////////////////////////
// Horizontal, in clocks.
////////////////////////////////////////

`define VGA_H_FRONT   16
`define VGA_H_SYNC    96
`define VGA_H_BACK    48
`define VGA_H_DISPLAY 640
`define VGA_H_BLANK   (`VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)   // 160.
`define VGA_H_TOTAL   (`VGA_H_BLANK + `VGA_H_DISPLAY)               // 800.

////////////////////////////////////////
// Vertical, in lines.
////////////////////////////////////////

`define VGA_V_FRONT   10
`define VGA_V_SYNC    2
`define VGA_V_BACK    33
`define VGA_V_DISPLAY 480
`define VGA_V_BLANK   (`VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)   // 45.
`define VGA_V_TOTAL   (`VGA_V_BLANK + `VGA_V_DISPLAY)               // 525.

////////////////////////////////////////
// Pixel buffer and idle colour.
////////////////////////////////////////

// Words held before the raster starts.
`define VGA_FIFO_DEPTH 16

// Yellow outside the display window.
`define VGA_BLANK_RGB 24'hFF_FF_00

`endif

/* common/vgaPkg.sv */
// Types only; colour is 8 bits per channel and coordinates cover up to 1023 pixels or lines.

package vgaPkg;

	////////////////////////////////////////
	// Colour word.
	////////////////////////////////////////

	// Red in the top byte, blue in the bottom byte.
	typedef struct packed {
		logic [7:0] red;   // DAC red channel.
		logic [7:0] green; // DAC green channel.
		logic [7:0] blue;  // DAC blue channel.
	} rgbT;

	////////////////////////////////////////
	// Raster coordinates.
	////////////////////////////////////////

	// Enough for the 800 clock line and the 525 line frame.
	typedef logic [9:0] coordT;

endpackage

/* verilog/patternGen.sv */
// Never stalls on its own; the only flow control is the FIFO full level, pushing once per free cycle.

`timescale 1ns/1ps

`include "vga_consts.svh"

module patternGen (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        full,
	output logic        push,
	output vgaPkg::rgbT pushData
);

	logic          run;    // Set one cycle after reset.
	vgaPkg::coordT px, py; // Raster position of the next word.

	// Push whenever there is room.
	assign push = run & ~full;

	////////////////////////////////////////
	// Pattern rule.
	////////////////////////////////////////

	assign pushData.red   = px[7:0];          // Low byte of x.
	assign pushData.green = py[7:0];          // Low byte of y.
	assign pushData.blue  = px[7:0] ^ py[7:0]; // Diagonal stripes.

	////////////////////////////////////////
	// Raster counters.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			px  <= '0;
			py  <= '0;
		end else begin
			run <= 1'b1;
			if (push) begin // Advance only on an accepted word.
				if (px == `VGA_H_DISPLAY - 1) begin
					px <= '0;
					// Last pixel of the frame wraps y too.
					py <= (py == `VGA_V_DISPLAY - 1) ? '0 : py + 1'b1;
				end else begin
					px <= px + 1'b1;
				end
			end
		end
	end

endmodule

/* pixelFifo/pixelFifo.sv */
// Single clock; read data appears one cycle after pop, and pop on empty or push on full is illegal.

`timescale 1ns/1ps

`include "vga_consts.svh"

module pixelFifo #(
	parameter int depth = `VGA_FIFO_DEPTH
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        push,
	input  vgaPkg::rgbT pushData,
	input  logic        pop,
	output vgaPkg::rgbT popData,
	output logic        full,
	output logic        empty
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	vgaPkg::rgbT     mem [depth]; // Word storage.
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;       // Words held.

	assign full  = (count == cntW'(depth));
	assign empty = (count == '0);

	////////////////////////////////////////
	// Storage and read register.
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData;
		if (pop)
			popData <= mem[rdPtr]; // Valid the cycle after pop.
	end

	////////////////////////////////////////
	// Pointers and occupancy.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1; // Any depth.
			if (pop)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither.
			endcase
		end
	end

	// The display fetch must never find the buffer dry.
	assertNoUnderflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty)
		else $error("pixelFifo: pop while empty");

	// The pattern source must respect the full level.
	assertNoOverflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !full)
		else $error("pixelFifo: push while full");

endmodule

/* vgaTiming/vgaTiming.sv */
// Waits for the first full FIFO, then runs free forever; each line is front porch, sync, back porch, display.

`timescale 1ns/1ps

`include "vga_consts.svh"

module vgaTiming #(
	parameter int hFrontLen   = `VGA_H_FRONT,
	parameter int hSyncLen    = `VGA_H_SYNC,
	parameter int hBackLen    = `VGA_H_BACK,
	parameter int hDisplayLen = `VGA_H_DISPLAY,
	parameter int vFrontLen   = `VGA_V_FRONT,
	parameter int vSyncLen    = `VGA_V_SYNC,
	parameter int vBackLen    = `VGA_V_BACK,
	parameter int vDisplayLen = `VGA_V_DISPLAY
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          full,
	output logic          fetch,
	output logic          active,
	output logic          hSync,
	output logic          vSync,
	output vgaPkg::coordT x,
	output vgaPkg::coordT y
);

	localparam int hBlank = hFrontLen + hSyncLen + hBackLen; // Display starts here.
	localparam int hTotal = hBlank + hDisplayLen;
	localparam int vBlank = vFrontLen + vSyncLen + vBackLen;
	localparam int vTotal = vBlank + vDisplayLen;

	logic          started;      // Start latch.
	logic          lineEnd;      // Last clock of a line.
	logic          inWindow;     // Current count is a display pixel.
	logic          nextInWindow; // Next count is a display pixel.
	vgaPkg::coordT hCount, vCount;
	vgaPkg::coordT hNext, vNext;

	////////////////////////////////////////
	// Next count.
	////////////////////////////////////////

	assign lineEnd = started && (hCount == hTotal - 1);

	always_comb begin
		hNext = hCount; // Frozen until started.
		vNext = vCount;
		if (started)
			hNext = lineEnd ? '0 : hCount + 1'b1;
		if (lineEnd)
			vNext = (vCount == vTotal - 1) ? '0 : vCount + 1'b1; // Frame wrap.
	end

	assign inWindow     = (hCount >= hBlank) && (vCount >= vBlank);
	assign nextInWindow = (hNext >= hBlank) && (vNext >= vBlank); // One cycle early.

	////////////////////////////////////////
	// Start latch and counters.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started <= 1'b0;
			hCount  <= '0;
			vCount  <= '0;
		end else begin
			if (!started && full)
				started <= 1'b1; // Never clears.
			hCount <= hNext;
			vCount <= vNext;
		end
	end

	////////////////////////////////////////
	// Registered decode.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hSync  <= 1'b1; // Syncs are active low.
			vSync  <= 1'b1;
			active <= 1'b0;
			fetch  <= 1'b0;
			x      <= '0;
			y      <= '0;
		end else begin
			hSync  <= !((hCount >= hFrontLen) && (hCount < hFrontLen + hSyncLen));
			vSync  <= !((vCount >= vFrontLen) && (vCount < vFrontLen + vSyncLen));
			active <= inWindow;
			fetch  <= nextInWindow; // Pop lands with active.
			x      <= inWindow ? vgaPkg::coordT'(hCount - hBlank) : '0;
			y      <= inWindow ? vgaPkg::coordT'(vCount - vBlank) : '0;
		end
	end

	assertHRange: assert property (@(posedge clk) disable iff (!rst_n)
		hCount < hTotal)
		else $error("vgaTiming: hCount out of range");

	// Display never overlaps a sync pulse.
	assertNoSyncActive: assert property (@(posedge clk) disable iff (!rst_n)
		active |-> (hSync && vSync))
		else $error("vgaTiming: active during sync");

	// FIFO data arrives exactly when the pixel is shown.
	assertFetchLead: assert property (@(posedge clk) disable iff (!rst_n)
		fetch |=> active)
		else $error("vgaTiming: fetch not followed by active");

endmodule

/* verilog/pixelOut.sv */
// One register stage; colour is only taken from the FIFO inside the display window.

`timescale 1ns/1ps

`include "vga_consts.svh"

module pixelOut (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          active,
	input  logic          hSync,
	input  logic          vSync,
	input  vgaPkg::coordT x,
	input  vgaPkg::coordT y,
	input  vgaPkg::rgbT   popData,
	output vgaPkg::rgbT   rgb,
	output logic          hs,
	output logic          vs,
	output logic          blankN,
	output vgaPkg::coordT outX,
	output vgaPkg::coordT outY
);

	localparam vgaPkg::rgbT blankRgb = `VGA_BLANK_RGB;

	vgaPkg::rgbT pixel; // Colour before the register.

	assign pixel = active ? popData : blankRgb;

	////////////////////////////////////////
	// DAC register.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb    <= blankRgb;
			hs     <= 1'b1; // Idle high.
			vs     <= 1'b1;
			blankN <= 1'b0;
			outX   <= '0;
			outY   <= '0;
		end else begin
			rgb    <= pixel;
			hs     <= hSync;
			vs     <= vSync;
			blankN <= active; // Same edge as colour.
			outX   <= x;
			outY   <= y;
		end
	end

endmodule

/* verilog/vgaTop.sv */
// Pixel clock is clk itself; the DAC samples on the inverted clock so data is stable mid-cycle.

`timescale 1ns/1ps

`include "vga_consts.svh"

module vgaTop (
	input  logic          clk,
	input  logic          rst_n,
	output vgaPkg::rgbT   rgb,
	output logic          hs,
	output logic          vs,
	output logic          blankN,
	output logic          vgaClk,
	output vgaPkg::coordT outX,
	output vgaPkg::coordT outY
);

	logic          push, pop, full;
	vgaPkg::rgbT   pushData, popData;
	logic          active, hSync, vSync;
	vgaPkg::coordT x, y;

	assign vgaClk = ~clk; // DAC clock.

	////////////////////////////////////////
	// Source and buffer.
	////////////////////////////////////////

	patternGen i_patternGen (
		.clk      (clk),
		.rst_n    (rst_n),
		.full     (full),
		.push     (push),
		.pushData (pushData)
	);

	pixelFifo #(.depth(`VGA_FIFO_DEPTH)) i_pixelFifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (push),
		.pushData (pushData),
		.pop      (pop),
		.popData  (popData),
		.full     (full),
		.empty    ()
	);

	////////////////////////////////////////
	// Raster and output.
	////////////////////////////////////////

	vgaTiming i_vgaTiming (
		.clk    (clk),
		.rst_n  (rst_n),
		.full   (full),
		.fetch  (pop), // One pop per display pixel.
		.active (active),
		.hSync  (hSync),
		.vSync  (vSync),
		.x      (x),
		.y      (y)
	);

	pixelOut i_pixelOut (
		.clk     (clk),
		.rst_n   (rst_n),
		.active  (active),
		.hSync   (hSync),
		.vSync   (vSync),
		.x       (x),
		.y       (y),
		.popData (popData),
		.rgb     (rgb),
		.hs      (hs),
		.vs      (vs),
		.blankN  (blankN),
		.outX    (outX),
		.outY    (outY)
	);

endmodule

/* verif/vgaTb.sv */
// Runs until two complete frames have been seen; all checks are concurrent assertions on clk edges.

`timescale 1ns/1ps

`include "vga_consts.svh"

module vgaTb;

	localparam int maxCycles = 2 * `VGA_H_TOTAL * `VGA_V_TOTAL + 60000; // 900000.
	localparam logic [46:0] resetVec = {3'b110, 20'd0, `VGA_BLANK_RGB};  // hs, vs, blankN, x, y, rgb.

	logic          clk   = 1'b0;
	logic          rst_n = 1'b0;
	vgaPkg::rgbT   rgb;
	logic          hs, vs, blankN, vgaClk;
	vgaPkg::coordT outX, outY;

	int            errs [1:5];      // Failures per test.
	string         names [1:5];
	int            cycles    = 0;   // Since time zero.
	int            relCycles = 0;   // Since reset release.
	int            hsLowLen  = 0;   // Consecutive low samples.
	int            hsPeriod  = 0;   // Cycles since last hs fall.
	int            vsLowLen  = 0;
	int            vsPeriod  = 0;
	int            runLen    = 0;   // Current blankN high run.
	int            runIdx    = 0;   // Runs finished this frame.
	int            vsFalls   = 0;
	logic          hsSeen     = 1'b0;
	logic          vsSeen     = 1'b0;
	logic          prevHs     = 1'b1;
	logic          prevVs     = 1'b1;
	logic          prevBlankN = 1'b0;
	vgaPkg::coordT prevOutX   = '0;
	vgaPkg::coordT prevOutY   = '0;

	vgaTop i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.rgb    (rgb),
		.hs     (hs),
		.vs     (vs),
		.blankN (blankN),
		.vgaClk (vgaClk),
		.outX   (outX),
		.outY   (outY)
	);

	always #5 clk = ~clk; // 10 ns period.

	// Reference colour of one pixel.
	function automatic vgaPkg::rgbT patternRgb(input vgaPkg::coordT px, input vgaPkg::coordT py);
		vgaPkg::rgbT c;
		c.red   = px[7:0];
		c.green = py[7:0];
		c.blue  = px[7:0] ^ py[7:0];
		return c;
	endfunction

	task automatic reportMismatch(input int testNo, input string sig, input longint expVal,
		input longint actVal);
		errs[testNo]++;
		$display("CHECK FAILED at %0t ns: test %0d %s expected %0d (0x%0h), got %0d (0x%0h)",
			$time, testNo, sig, expVal, expVal, actVal, actVal);
	endtask

	////////////////////////////////////////
	// Pulse and period counters.
	////////////////////////////////////////

	always @(posedge clk) begin
		cycles     <= cycles + 1;
		prevHs     <= hs;
		prevVs     <= vs;
		prevBlankN <= blankN;
		prevOutX   <= outX;
		prevOutY   <= outY;
		if (rst_n)
			relCycles <= relCycles + 1;
		hsLowLen <= hs ? 0 : hsLowLen + 1;
		vsLowLen <= vs ? 0 : vsLowLen + 1;
		runLen   <= blankN ? runLen + 1 : 0;
		hsPeriod <= (prevHs && !hs) ? 1 : hsPeriod + 1; // Restart on a fall.
		vsPeriod <= (prevVs && !vs) ? 1 : vsPeriod + 1;
		if (rst_n && prevHs && !hs)
			hsSeen <= 1'b1;
		if (rst_n && prevVs && !vs) begin // Frame boundary.
			vsSeen  <= 1'b1;
			vsFalls <= vsFalls + 1;
			runIdx  <= 0;
		end else if (prevBlankN && !blankN) begin
			runIdx <= runIdx + 1;
		end
		if (cycles == maxCycles) begin
			$display("Timeout after %0d cycles: two full frames were not seen", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Checks.
	////////////////////////////////////////

	// Test 1. Reset values, and no early start.
	resetState: assert property (@(posedge clk) (cycles > 0) && (!rst_n || $rose(rst_n)) |->
		{hs, vs, blankN, outX, outY, rgb} == resetVec)
		else reportMismatch(1, "{hs,vs,blankN,outX,outY,rgb}", resetVec,
			$sampled({hs, vs, blankN, outX, outY, rgb}));
	// FIFO fill, then the front porch.
	firstHsFall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hs) && !hsSeen |-> relCycles >= `VGA_FIFO_DEPTH + `VGA_H_FRONT)
		else reportMismatch(1, "cycles to first hs fall (minimum)",
			`VGA_FIFO_DEPTH + `VGA_H_FRONT, $sampled(relCycles));

	// Test 2. Horizontal sync.
	hsWidth: assert property (@(posedge clk) disable iff (!rst_n) $rose(hs) |->
		hsLowLen == `VGA_H_SYNC)
		else reportMismatch(2, "hs low length", `VGA_H_SYNC, $sampled(hsLowLen));
	hsPeriodChk: assert property (@(posedge clk) disable iff (!rst_n) $fell(hs) && hsSeen |->
		hsPeriod == `VGA_H_TOTAL)
		else reportMismatch(2, "hs period", `VGA_H_TOTAL, $sampled(hsPeriod));

	// Test 3. Vertical sync, in clocks.
	vsWidth: assert property (@(posedge clk) disable iff (!rst_n) $rose(vs) |->
		vsLowLen == `VGA_V_SYNC * `VGA_H_TOTAL)
		else reportMismatch(3, "vs low length", `VGA_V_SYNC * `VGA_H_TOTAL, $sampled(vsLowLen));
	vsPeriodChk: assert property (@(posedge clk) disable iff (!rst_n) $fell(vs) && vsSeen |->
		vsPeriod == `VGA_V_TOTAL * `VGA_H_TOTAL)
		else reportMismatch(3, "vs period", `VGA_V_TOTAL * `VGA_H_TOTAL, $sampled(vsPeriod));

	// Test 4. Display runs and coordinates.
	runWidth: assert property (@(posedge clk) disable iff (!rst_n) $fell(blankN) |->
		runLen == `VGA_H_DISPLAY)
		else reportMismatch(4, "blankN run length", `VGA_H_DISPLAY, $sampled(runLen));
	runStartX: assert property (@(posedge clk) disable iff (!rst_n) $rose(blankN) |-> outX == 0)
		else reportMismatch(4, "outX at run start", 0, $sampled(outX));
	runStartY: assert property (@(posedge clk) disable iff (!rst_n) $rose(blankN) |->
		outY == runIdx)
		else reportMismatch(4, "outY at run start", $sampled(runIdx), $sampled(outY));
	runStepX: assert property (@(posedge clk) disable iff (!rst_n) blankN && prevBlankN |->
		outX == prevOutX + 1'b1)
		else reportMismatch(4, "outX step", $sampled(prevOutX) + 1, $sampled(outX));
	runHoldY: assert property (@(posedge clk) disable iff (!rst_n) blankN && prevBlankN |->
		outY == prevOutY)
		else reportMismatch(4, "outY within run", $sampled(prevOutY), $sampled(outY));
	frameRuns: assert property (@(posedge clk) disable iff (!rst_n) $fell(vs) && vsSeen |->
		runIdx == `VGA_V_DISPLAY)
		else reportMismatch(4, "runs per frame", `VGA_V_DISPLAY, $sampled(runIdx));

	// Test 5. Colour inside and outside the window.
	colourOn: assert property (@(posedge clk) disable iff (!rst_n) blankN |->
		rgb == patternRgb(outX, outY))
		else reportMismatch(5, "rgb", patternRgb($sampled(outX), $sampled(outY)), $sampled(rgb));
	colourOff: assert property (@(posedge clk) disable iff (!rst_n) !blankN |->
		rgb == `VGA_BLANK_RGB)
		else reportMismatch(5, "rgb when blank", `VGA_BLANK_RGB, $sampled(rgb));

	// DAC clock runs opposite to clk.
	dacClkHigh: assert property (@(posedge clk) vgaClk)
		else reportMismatch(5, "vgaClk before clk rise", 1, $sampled(vgaClk));
	dacClkLow: assert property (@(negedge clk) !vgaClk)
		else reportMismatch(5, "vgaClk before clk fall", 0, $sampled(vgaClk));

	////////////////////////////////////////
	// Reset, run and report.
	////////////////////////////////////////

	initial begin
		int t;
		int failedTests;
		int totalErrs;
		failedTests = 0;
		totalErrs   = 0;
		names[1] = "reset state";
		names[2] = "horizontal sync";
		names[3] = "vertical sync";
		names[4] = "display window";
		names[5] = "colour";
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (vsFalls < 3) // Third vs fall closes the second frame.
			@(posedge clk);
		@(posedge clk);
		for (t = 1; t <= 5; t++) begin
			$display("Test %0d %s: %s (%0d errors)", t, names[t],
				(errs[t] == 0) ? "pass" : "fail", errs[t]);
			if (errs[t] != 0)
				failedTests++;
			totalErrs += errs[t];
		end
		$display("Tests: %0d passed, %0d failed, %0d check errors", 5 - failedTests,
			failedTests, totalErrs);
		if (failedTests == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/vgaPkg.sv
verilog/patternGen.sv
pixelFifo/pixelFifo.sv
vgaTiming/vgaTiming.sv
verilog/pixelOut.sv
verilog/vgaTop.sv
verif/vgaTb.sv

/* Makefile */
# Verilator build and run of the VGA testbench.
TOP := vgaTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
